/* ref_tag_cache_pkg.sv */
package ref_tag_cache_pkg;

   // ----------------------------------------
   // request address layout
   // ----------------------------------------
   // adr = {ref_idx, block_y, block_x}, block x in the low bits

   localparam int REF_W = 2;                     // reference index
   localparam int BLK_W = 6;                     // block y and block x each
   localparam int ADR_W = REF_W + 2 * BLK_W;     // 14

   // ----------------------------------------
   // cache geometry
   // ----------------------------------------

   localparam int N_WAYS    = 4;
   localparam int WAY_W     = 2;
   localparam int DEF_SET_W = 4;                 // 16 sets, must be even

   typedef logic [ADR_W-1:0] blk_adr_t;
   typedef logic [WAY_W-1:0] way_t;

   // 0 is most recently used, N_WAYS-1 least recently used
   typedef logic [WAY_W-1:0] age_t;

   // lookup sequencing, one request in flight
   typedef enum logic [1:0] {
      IDLE,       // waiting for a strobe
      READ,       // tag and valid read issued
      COMPARE,    // way data valid, pick and update
      RESPOND     // ack with results
   } lookup_state_t;

endpackage

/* lookup_ctrl.sv */
module lookup_ctrl #(
   parameter int SET_W = ref_tag_cache_pkg::DEF_SET_W
) (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      cyc,
   input  logic                                      stb,
   input  ref_tag_cache_pkg::blk_adr_t               adr,
   input  logic                                      done,
   output logic                                      ack,
   output logic                                      rd_en,
   output logic                                      cmp_en,
   output logic [SET_W-1:0]                          set_idx,
   output logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] req_tag
);
   import ref_tag_cache_pkg::*;

   localparam int HALF  = SET_W / 2;
   localparam int TAG_W = ADR_W - SET_W;

   lookup_state_t     state;
   lookup_state_t     state_nxt;
   logic              accept;
   logic [SET_W-1:0]  set_split;
   logic [TAG_W-1:0]  tag_split;

   // set = low bits of x joined with low bits of y, tag = everything else
   assign set_split = {adr[HALF-1:0], adr[BLK_W+HALF-1:BLK_W]};
   assign tag_split = {adr[ADR_W-1:BLK_W+HALF], adr[BLK_W-1:HALF]};

   assign accept = (state == IDLE) && cyc && stb;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (accept) begin
               state_nxt = READ;
            end
         end
         READ:    state_nxt = COMPARE;
         COMPARE: state_nxt = RESPOND;
         RESPOND: state_nxt = IDLE;      // master drops stb on this edge
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // request held for the whole lookup
   always_ff @(posedge clk) begin
      if (accept) begin
         set_idx <= set_split;
         req_tag <= tag_split;
      end
   end

   assign rd_en  = (state == READ);
   assign cmp_en = (state == COMPARE);
   assign ack    = (state == RESPOND) && done;

   // ----------------------------------------
   // bus checks
   // ----------------------------------------

   ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
      ack |-> cyc && stb)
      else $error("ack outside an active strobe");

   ack_latency: assert property (@(posedge clk) disable iff (reset)
      accept |-> ##3 ack)
      else $error("ack not 3 cycles after accept");

endmodule

/* tag_way.sv */
module tag_way #(
   parameter int SET_W = ref_tag_cache_pkg::DEF_SET_W
) (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      rd_en,
   input  logic [SET_W-1:0]                          set_idx,
   input  logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] req_tag,
   input  logic                                      fill,
   input  logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] fill_tag,
   output logic                                      match,
   output logic                                      valid,
   output logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] stored_tag
);
   import ref_tag_cache_pkg::*;

   localparam int TAG_W  = ADR_W - SET_W;
   localparam int N_SETS = 1 << SET_W;

   logic [TAG_W-1:0]  tag_mem [N_SETS];
   logic [N_SETS-1:0] valid_mem;
   logic [SET_W-1:0]  rd_set;      // set of the lookup in flight
   logic [TAG_W-1:0]  rd_tag;
   logic              rd_valid;

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_set <= set_idx;
         rd_tag <= tag_mem[set_idx];
      end
      if (fill) begin
         tag_mem[rd_set] <= fill_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_mem <= '0;
         rd_valid  <= 1'b0;
      end else begin
         if (rd_en) begin
            rd_valid <= valid_mem[set_idx];
         end
         if (fill) begin
            valid_mem[rd_set] <= 1'b1;
         end
      end
   end

   assign match      = rd_valid && (rd_tag == req_tag);
   assign valid      = rd_valid;
   assign stored_tag = rd_tag;

endmodule

/* lru_replace.sv */
module lru_replace #(
   parameter int SET_W = ref_tag_cache_pkg::DEF_SET_W
) (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      cmp_en,
   input  logic [SET_W-1:0]                          set_idx,
   input  logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] req_tag,
   input  logic [ref_tag_cache_pkg::N_WAYS-1:0]      match_vec,
   input  logic [ref_tag_cache_pkg::N_WAYS-1:0]      valid_vec,
   input  logic [ref_tag_cache_pkg::N_WAYS-1:0][ref_tag_cache_pkg::ADR_W-SET_W-1:0] tag_vec,
   output logic [ref_tag_cache_pkg::N_WAYS-1:0]      fill_vec,
   output logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] fill_tag,
   output logic                                      done,
   output logic                                      hit,
   output ref_tag_cache_pkg::way_t                   way,
   output logic                                      victim_valid,
   output logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] victim_tag
);
   import ref_tag_cache_pkg::*;

   localparam int TAG_W  = ADR_W - SET_W;
   localparam int N_SETS = 1 << SET_W;

   age_t              ages [N_SETS][N_WAYS];
   age_t              set_ages [N_WAYS];
   age_t              new_ages [N_WAYS];
   age_t              old_age;
   way_t              hit_way;
   way_t              inv_way;
   way_t              lru_way;
   way_t              sel_way;
   logic              hit_c;
   logic              inv_found;
   logic              victim_valid_c;
   logic [TAG_W-1:0]  victim_tag_c;

   // ----------------------------------------
   // way selection
   // ----------------------------------------

   always_comb begin
      hit_c     = |match_vec;
      hit_way   = '0;
      inv_way   = '0;
      lru_way   = '0;
      inv_found = 1'b0;
      for (int w = 0; w < N_WAYS; w++) begin
         set_ages[w] = ages[set_idx][w];
         if (match_vec[w]) begin
            hit_way = way_t'(w);
         end
         if (set_ages[w] == age_t'(N_WAYS - 1)) begin
            lru_way = way_t'(w);
         end
      end
      // walk down so the lowest invalid way wins
      for (int w = N_WAYS - 1; w >= 0; w--) begin
         if (!valid_vec[w]) begin
            inv_found = 1'b1;
            inv_way   = way_t'(w);
         end
      end
      if (hit_c) begin
         sel_way = hit_way;
      end else if (inv_found) begin
         sel_way = inv_way;
      end else begin
         sel_way = lru_way;
      end
      old_age = set_ages[sel_way];
   end

   // chosen way goes to 0, younger ways age by one
   always_comb begin
      for (int w = 0; w < N_WAYS; w++) begin
         if (way_t'(w) == sel_way) begin
            new_ages[w] = '0;
         end else if (set_ages[w] < old_age) begin
            new_ages[w] = set_ages[w] + 1'b1;
         end else begin
            new_ages[w] = set_ages[w];
         end
         fill_vec[w] = cmp_en && !hit_c && (way_t'(w) == sel_way);
      end
   end

   assign fill_tag       = req_tag;
   assign victim_valid_c = !hit_c && valid_vec[sel_way];
   assign victim_tag_c   = victim_valid_c ? tag_vec[sel_way] : '0;

   // ----------------------------------------
   // age store and results
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < N_SETS; s++) begin
            for (int w = 0; w < N_WAYS; w++) begin
               ages[s][w] <= age_t'(w);
            end
         end
      end else if (cmp_en) begin
         for (int w = 0; w < N_WAYS; w++) begin
            ages[set_idx][w] <= new_ages[w];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         done <= 1'b0;
      end else begin
         done <= cmp_en;
      end
   end

   always_ff @(posedge clk) begin
      if (cmp_en) begin
         hit          <= hit_c;
         way          <= sel_way;
         victim_valid <= victim_valid_c;
         victim_tag   <= victim_tag_c;
      end
   end

   fill_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(fill_vec))
      else $error("more than one way filled");

   match_onehot: assert property (@(posedge clk) disable iff (reset)
      cmp_en |-> $onehot0(match_vec))
      else $error("tag present in more than one way");

endmodule

/* tag_cache_bank.sv */
module tag_cache_bank #(
   parameter int SET_W = ref_tag_cache_pkg::DEF_SET_W
) (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      cyc,
   input  logic                                      stb,
   input  ref_tag_cache_pkg::blk_adr_t               adr,
   output logic                                      ack,
   output logic                                      hit,
   output ref_tag_cache_pkg::way_t                   way,
   output logic                                      victim_valid,
   output logic [ref_tag_cache_pkg::ADR_W-SET_W-1:0] victim_tag
);
   import ref_tag_cache_pkg::*;

   localparam int TAG_W = ADR_W - SET_W;

   logic                          done;
   logic                          rd_en;
   logic                          cmp_en;
   logic [SET_W-1:0]              set_idx;
   logic [TAG_W-1:0]              req_tag;
   logic [N_WAYS-1:0]             match_vec;
   logic [N_WAYS-1:0]             valid_vec;
   logic [N_WAYS-1:0][TAG_W-1:0]  tag_vec;
   logic [N_WAYS-1:0]             fill_vec;
   logic [TAG_W-1:0]              fill_tag;

   lookup_ctrl #(.SET_W(SET_W)) lookup_ctrl_inst (
      .clk     (clk),
      .reset   (reset),
      .cyc     (cyc),
      .stb     (stb),
      .adr     (adr),
      .done    (done),
      .ack     (ack),
      .rd_en   (rd_en),
      .cmp_en  (cmp_en),
      .set_idx (set_idx),
      .req_tag (req_tag)
   );

   for (genvar i = 0; i < N_WAYS; i++) begin : way_gen
      tag_way #(.SET_W(SET_W)) tag_way_inst (
         .clk        (clk),
         .reset      (reset),
         .rd_en      (rd_en),
         .set_idx    (set_idx),
         .req_tag    (req_tag),
         .fill       (fill_vec[i]),
         .fill_tag   (fill_tag),
         .match      (match_vec[i]),
         .valid      (valid_vec[i]),
         .stored_tag (tag_vec[i])
      );
   end

   lru_replace #(.SET_W(SET_W)) lru_replace_inst (
      .clk          (clk),
      .reset        (reset),
      .cmp_en       (cmp_en),
      .set_idx      (set_idx),
      .req_tag      (req_tag),
      .match_vec    (match_vec),
      .valid_vec    (valid_vec),
      .tag_vec      (tag_vec),
      .fill_vec     (fill_vec),
      .fill_tag     (fill_tag),
      .done         (done),
      .hit          (hit),
      .way          (way),
      .victim_valid (victim_valid),
      .victim_tag   (victim_tag)
   );

endmodule

/* tb_tag_cache_bank.sv */
module tb_tag_cache_bank;
   import ref_tag_cache_pkg::*;

   localparam int SET_W    = DEF_SET_W;
   localparam int TAG_W    = ADR_W - SET_W;
   localparam int LATENCY  = 3;
   localparam int ACK_WAIT = 8;

   logic              clk;
   logic              reset;
   logic              cyc;
   logic              stb;
   blk_adr_t          adr;
   logic              ack;
   logic              hit;
   way_t              way;
   logic              victim_valid;
   logic [TAG_W-1:0]  victim_tag;

   logic              is_reset_q [$];
   blk_adr_t          adr_q [$];
   logic              hit_q [$];
   way_t              way_q [$];
   logic              vv_q [$];
   logic [TAG_W-1:0]  vtag_q [$];
   int                cur_line    = 0;
   int                cycle_count = 0;
   int                cycle_limit = 0;

   tag_cache_bank #(.SET_W(SET_W)) tag_cache_bank_inst (
      .clk          (clk),
      .reset        (reset),
      .cyc          (cyc),
      .stb          (stb),
      .adr          (adr),
      .ack          (ack),
      .hit          (hit),
      .way          (way),
      .victim_valid (victim_valid),
      .victim_tag   (victim_tag)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      lookup_state_t st;
      st = tag_cache_bank_inst.lookup_ctrl_inst.state;
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles in test %0d, lookup state %s",
                  cycle_count, cur_line, st.name());
         $display("STATUS: FAIL");
         $fatal(1, "simulation did not finish in time");
      end
   end

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------

   task automatic check_flag(input string field, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t test %0d %s: got %b, expected %b", $time, cur_line, field,
                  got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic check_way(input string field, input way_t got, input way_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t test %0d %s: got %0d, expected %0d", $time, cur_line, field,
                  got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "way mismatch");
      end
   endtask

   task automatic check_tag(input string field, input logic [TAG_W-1:0] got,
                            input logic [TAG_W-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t test %0d %s: got %h, expected %h", $time, cur_line, field,
                  got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "tag mismatch");
      end
   endtask

   task automatic check_latency(input string field, input int got, input int exp);
      if (got != exp) begin
         $display("[FAIL] %0t test %0d %s: got %0d cycles, expected %0d", $time, cur_line,
                  field, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "latency mismatch");
      end
   endtask

   // ----------------------------------------
   // stimulus
   // ----------------------------------------

   task automatic read_tests();
      int                fd;
      int                code;
      string             line;
      blk_adr_t          a;
      logic              h;
      way_t              w;
      logic              vv;
      logic [TAG_W-1:0]  vt;
      fd = $fopen("cache_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open cache_tests.txt");
         $display("STATUS: FAIL");
         $fatal(1, "missing tests file");
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
            if (line.len() >= 5 && line.substr(0, 4) == "reset") begin
               a  = '0;
               h  = 1'b0;
               w  = '0;
               vv = 1'b0;
               vt = '0;
               is_reset_q.push_back(1'b1);
            end else begin
               code = $sscanf(line, "%h %d %d %d %h", a, h, w, vv, vt);
               if (code != 5) begin
                  $display("malformed line in cache_tests.txt: %s", line);
                  $display("STATUS: FAIL");
                  $fatal(1, "bad tests file");
               end
               is_reset_q.push_back(1'b0);
            end
            adr_q.push_back(a);
            hit_q.push_back(h);
            way_q.push_back(w);
            vv_q.push_back(vv);
            vtag_q.push_back(vt);
         end
      end
      $fclose(fd);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      cyc   <= 1'b0;
      stb   <= 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic run_lookup(input int n);
      int    cycles;
      logic  ack_seen;
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      adr <= adr_q[n];
      @(posedge clk);            // accept edge
      cycles   = 0;
      ack_seen = 1'b0;
      while (!ack_seen && cycles < ACK_WAIT) begin
         @(negedge clk);
         cycles++;
         ack_seen = ack;
      end
      if (!ack_seen) begin
         $display("no ack within %0d cycles of accepting test %0d", ACK_WAIT, n);
         $display("STATUS: FAIL");
         $fatal(1, "missing ack");
      end
      check_latency("ack latency", cycles, LATENCY);
      check_flag("hit", hit, hit_q[n]);
      check_way("way", way, way_q[n]);
      check_flag("victim_valid", victim_valid, vv_q[n]);
      if (vv_q[n]) begin
         check_tag("victim_tag", victim_tag, vtag_q[n]);
      end
      @(posedge clk);            // master drops stb on the ack edge
      cyc <= 1'b0;
      stb <= 1'b0;
      @(negedge clk);
      check_flag("ack one cycle", ack, 1'b0);
   endtask

   initial begin
      int lookups;
      clk     = 1'b0;
      reset   = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      adr     = '0;
      lookups = 0;
      read_tests();
      cycle_limit = 6 * is_reset_q.size() + 20;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < is_reset_q.size(); i++) begin
         cur_line = i;
         if (is_reset_q[i]) begin
            apply_reset();
         end else begin
            run_lookup(i);
            lookups++;
         end
      end
      if (lookups == 0) begin
         $display("no lookups found in cache_tests.txt");
         $display("STATUS: FAIL");
         $fatal(1, "empty tests file");
      end else begin
         $display("%0d lookups checked", lookups);
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

/* cache_tests.txt */
# adr(hex) hit way victim_valid victim_tag(hex)
# a line holding only reset pulses the bank reset
# set 0 cold misses fill ways 0..3
0004 0 0 0 000
0008 0 1 0 000
0100 0 2 0 000
1000 0 3 0 000
# hits move ways to the front
0004 1 0 0 000
0100 1 2 0 000
0004 1 0 0 000
# full set evicts the oldest way
203c 0 1 1 002
0008 0 3 1 100
203c 1 1 0 000
1000 0 2 1 010
# same tag bits in other sets
0044 0 0 0 000
0005 0 0 0 000
0044 1 0 0 000
0004 1 0 0 000
0048 0 1 0 000
00c7 0 0 0 000
reset
0004 0 0 0 000
0044 0 0 0 000
0004 1 0 0 000
0008 0 1 0 000

/* ref_tag_cache.f */
ref_tag_cache_pkg.sv
lookup_ctrl.sv
tag_way.sv
lru_replace.sv
tag_cache_bank.sv
tb_tag_cache_bank.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tag_cache_bank
FILELIST  ?= ref_tag_cache.f
FLAGS     ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) cache_tests.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
